// ==== gf_alu_consts.svh ====
// field widths, lane count, opcodes, reduction polynomial and MAC pipeline depth
`ifndef GF_ALU_CONSTS_SVH
`define GF_ALU_CONSTS_SVH

// field element and vector geometry
`define GF_M        16
`define GF_LANES    9
`define GF_VEC_W    144

// low terms of x^16+x^5+x^3+x^2+1
`define GF_POLY     16'h002d

// latency of one multiply-add lane
`define MAC_STAGES  3

// opcodes on alu_typ_sel
`define ALU_TYP_W   4
`define OP_ADD      4'd1
`define OP_MUL      4'd3
`define OP_GT       4'd4
`define OP_RSHIFT   4'd8
`define OP_EVAL     4'd9

`endif

// ==== gf_alu_pkg.sv ====
// field element type, two-view vector union and opcode enumeration
`include "gf_alu_consts.svh"

package gf_alu_pkg;

	// one GF(2^16) element
	typedef logic [`GF_M-1:0] gf_elem_t;

	// one operand or result word
	// flat view for xor and shift, lane view for per-element work
	// lane 0 sits in the most significant bits
	typedef union packed {
		logic [`GF_VEC_W-1:0] flat;
		gf_elem_t [0:`GF_LANES-1] lanes;
	} gf_vec_u;

	// supported operations
	typedef enum logic [`ALU_TYP_W-1:0] {
		op_add    = `OP_ADD,
		op_mul    = `OP_MUL,
		op_gt     = `OP_GT,
		op_rshift = `OP_RSHIFT,
		op_eval   = `OP_EVAL
	} alu_op_e;

endpackage

// ==== alu_cmd_front.sv ====
// command front end with operand capture, opcode decode, start routing and busy flag
`timescale 1ns/10ps

module alu_cmd_front (
	input  logic                clk,
	input  logic                rst_b,
	input  logic                alu_o_sel,
	input  logic                alu_t_sel,
	input  gf_alu_pkg::alu_op_e alu_typ_sel,
	input  gf_alu_pkg::gf_vec_u alu_o_dat,
	input  gf_alu_pkg::gf_vec_u alu_t_dat,
	input  logic                compute_done,
	output gf_alu_pkg::gf_vec_u opnd_o,
	output gf_alu_pkg::gf_vec_u opnd_t,
	output gf_alu_pkg::alu_op_e op_typ,
	output logic                op_start,
	output logic                eval_start
);

	logic busy;
	logic known_op;
	logic accept;

	// only the five kept opcodes start anything
	always_comb begin
		case (alu_typ_sel)
			gf_alu_pkg::op_add, gf_alu_pkg::op_mul, gf_alu_pkg::op_gt,
			gf_alu_pkg::op_rshift, gf_alu_pkg::op_eval: known_op = 1'b1;
			default: known_op = 1'b0;
		endcase
	end

	assign accept = alu_o_sel & alu_t_sel & ~busy & known_op;

	always_ff @(posedge clk) begin
		if (accept) begin
			opnd_o <= alu_o_dat;
			opnd_t <= alu_t_dat;
		end
	end

	always_ff @(posedge clk or negedge rst_b) begin
		if (!rst_b) begin
			busy       <= 1'b0;
			op_typ     <= gf_alu_pkg::op_add;
			op_start   <= 1'b0;
			eval_start <= 1'b0;
		end else begin
			// eval goes to the sequencer, all else to the result stage
			op_start   <= accept && (alu_typ_sel != gf_alu_pkg::op_eval);
			eval_start <= accept && (alu_typ_sel == gf_alu_pkg::op_eval);
			if (accept) begin
				busy   <= 1'b1;
				op_typ <= alu_typ_sel;
			end else if (compute_done) begin
				busy <= 1'b0;
			end
		end
	end

endmodule

// ==== gf_mac_array.sv ====
// nine pipelined GF(2^16) multiply-add lanes computing a*b+c
`timescale 1ns/10ps
`include "gf_alu_consts.svh"

module gf_mac_array (
	input  logic                clk,
	input  logic                rst_b,
	input  gf_alu_pkg::gf_vec_u mac_a,
	input  gf_alu_pkg::gf_vec_u mac_b,
	input  gf_alu_pkg::gf_vec_u mac_c,
	output gf_alu_pkg::gf_vec_u mac_r
);

	gf_alu_pkg::gf_elem_t r_q [0:`GF_LANES-1];

	// carry-less product, 31 bits wide
	function automatic logic [2*`GF_M-2:0] clmul(input gf_alu_pkg::gf_elem_t a,
			input gf_alu_pkg::gf_elem_t b);
		logic [2*`GF_M-2:0] p;
		p = '0;
		for (int i = 0; i < `GF_M; i++) begin
			if (b[i])
				p = p ^ ({{(`GF_M-1){1'b0}}, a} << i);
		end
		return p;
	endfunction

	// fold the high terms back using x^16 = x^5+x^3+x^2+1
	function automatic gf_alu_pkg::gf_elem_t reduce(input logic [2*`GF_M-2:0] p_in);
		logic [2*`GF_M-2:0] p;
		logic [2*`GF_M-2:0] f;
		p = p_in;
		f = {{(`GF_M-2){1'b0}}, 1'b1, `GF_POLY};
		for (int i = 2*`GF_M-2; i >= `GF_M; i--) begin
			if (p[i])
				p = p ^ (f << (i - `GF_M));
		end
		return p[`GF_M-1:0];
	endfunction

	for (genvar g = 0; g < `GF_LANES; g++) begin : g_lane
		logic [2*`GF_M-2:0]   prod_q;
		gf_alu_pkg::gf_elem_t red_q;
		gf_alu_pkg::gf_elem_t c_d1;
		gf_alu_pkg::gf_elem_t c_d2;

		always_ff @(posedge clk or negedge rst_b) begin
			if (!rst_b) begin
				prod_q <= '0;
				red_q  <= '0;
				c_d1   <= '0;
				c_d2   <= '0;
				r_q[g] <= '0;
			end else begin
				prod_q <= clmul(mac_a.lanes[g], mac_b.lanes[g]);
				c_d1   <= mac_c.lanes[g];
				red_q  <= reduce(prod_q);
				c_d2   <= c_d1;
				r_q[g] <= red_q ^ c_d2;
			end
		end
	end

	always_comb begin
		for (int i = 0; i < `GF_LANES; i++)
			mac_r.lanes[i] = r_q[i];
	end

endmodule

// ==== poly_eval_seq.sv ====
// Horner evaluation sequencer driving MAC lane 0 for the EVAL operation
`timescale 1ns/10ps
`include "gf_alu_consts.svh"

module poly_eval_seq (
	input  logic                 clk,
	input  logic                 rst_b,
	input  logic                 eval_start,
	input  gf_alu_pkg::gf_vec_u  opnd_o,
	input  gf_alu_pkg::gf_vec_u  opnd_t,
	input  gf_alu_pkg::gf_elem_t mac_lane0,
	output logic                 eval_active,
	output gf_alu_pkg::gf_elem_t eval_a,
	output gf_alu_pkg::gf_elem_t eval_b,
	output gf_alu_pkg::gf_elem_t eval_c,
	output logic                 eval_done,
	output gf_alu_pkg::gf_elem_t eval_value
);

	localparam int STEP_W = $clog2(`GF_LANES);
	localparam int WAIT_W = $clog2(`MAC_STAGES + 1);

	gf_alu_pkg::gf_elem_t acc;
	logic [STEP_W-1:0]    step;
	logic [WAIT_W-1:0]    wait_cnt;
	logic                 step_ready;

	// acc * point + next coefficient, held steady for the whole step
	assign eval_a = acc;
	assign eval_b = opnd_t.lanes[`GF_LANES-1];
	assign eval_c = opnd_o.lanes[step];

	assign eval_value = acc;

	// lane 0 output reflects this step's inputs once the pipe has filled
	assign step_ready = eval_active && (wait_cnt == WAIT_W'(`MAC_STAGES));

	// ============================================================================
	// step control
	// ============================================================================
	always_ff @(posedge clk or negedge rst_b) begin
		if (!rst_b) begin
			eval_active <= 1'b0;
			eval_done   <= 1'b0;
			acc         <= '0;
			step        <= '0;
			wait_cnt    <= '0;
		end else begin
			eval_done <= 1'b0;
			if (eval_start) begin
				eval_active <= 1'b1;
				acc         <= opnd_o.lanes[0];
				step        <= STEP_W'(1);
				wait_cnt    <= '0;
			end else if (step_ready) begin
				acc      <= mac_lane0;
				wait_cnt <= '0;
				if (step == STEP_W'(`GF_LANES - 1)) begin
					// constant term folded in, value is final
					eval_active <= 1'b0;
					eval_done   <= 1'b1;
				end else begin
					step <= step + 1'b1;
				end
			end else if (eval_active) begin
				wait_cnt <= wait_cnt + 1'b1;
			end
		end
	end

endmodule

// ==== alu_result_stage.sv ====
// single-cycle ops, MAC input muxing, MUL latency tracking, result and done registers
`timescale 1ns/10ps
`include "gf_alu_consts.svh"

module alu_result_stage (
	input  logic                 clk,
	input  logic                 rst_b,
	input  logic                 op_start,
	input  gf_alu_pkg::alu_op_e  op_typ,
	input  gf_alu_pkg::gf_vec_u  opnd_o,
	input  gf_alu_pkg::gf_vec_u  opnd_t,
	input  gf_alu_pkg::gf_vec_u  mac_r,
	input  logic                 eval_active,
	input  gf_alu_pkg::gf_elem_t eval_a,
	input  gf_alu_pkg::gf_elem_t eval_b,
	input  gf_alu_pkg::gf_elem_t eval_c,
	input  logic                 eval_done,
	input  gf_alu_pkg::gf_elem_t eval_value,
	output gf_alu_pkg::gf_vec_u  mac_a,
	output gf_alu_pkg::gf_vec_u  mac_b,
	output gf_alu_pkg::gf_vec_u  mac_c,
	output gf_alu_pkg::gf_vec_u  alu_r_dat1,
	output gf_alu_pkg::gf_vec_u  alu_r_dat2,
	output logic                 compute_done
);

	logic [`MAC_STAGES-1:0] mul_v;
	logic                   mul_go;
	logic                   quick_go;
	logic                   t_gt_o;

	assign mul_go   = op_start && (op_typ == gf_alu_pkg::op_mul);
	assign quick_go = op_start && (op_typ != gf_alu_pkg::op_mul);

	// unsigned compare of the low elements
	assign t_gt_o = opnd_t.lanes[`GF_LANES-1] > opnd_o.lanes[`GF_LANES-1];

	// ============================================================================
	// array inputs
	// ============================================================================
	always_comb begin
		// scalar multiply by t lane 8 on every lane
		mac_a = opnd_o;
		for (int i = 0; i < `GF_LANES; i++)
			mac_b.lanes[i] = opnd_t.lanes[`GF_LANES-1];
		mac_c.flat = '0;
		if (eval_active) begin
			mac_a.lanes[0] = eval_a;
			mac_b.lanes[0] = eval_b;
			mac_c.lanes[0] = eval_c;
		end
	end

	// ============================================================================
	// results
	// ============================================================================
	always_ff @(posedge clk or negedge rst_b) begin
		if (!rst_b) begin
			mul_v        <= '0;
			compute_done <= 1'b0;
			alu_r_dat1   <= '0;
			alu_r_dat2   <= '0;
		end else begin
			mul_v        <= {mul_v[`MAC_STAGES-2:0], mul_go};
			compute_done <= quick_go | mul_v[`MAC_STAGES-1] | eval_done;
			if (quick_go) begin
				alu_r_dat2.flat <= '0;
				case (op_typ)
					gf_alu_pkg::op_add:
						alu_r_dat1.flat <= opnd_o.flat ^ opnd_t.flat;
					gf_alu_pkg::op_gt:
						alu_r_dat1.flat <= {t_gt_o, {(`GF_VEC_W-1){1'b0}}};
					gf_alu_pkg::op_rshift: begin
						alu_r_dat1.flat <= {{`GF_M{1'b0}}, opnd_o.flat[`GF_VEC_W-1:`GF_M]};
						alu_r_dat2.flat <= {opnd_o.lanes[`GF_LANES-1],
							{(`GF_VEC_W-`GF_M){1'b0}}};
					end
					default:
						alu_r_dat1.flat <= '0;
				endcase
			end else if (mul_v[`MAC_STAGES-1]) begin
				alu_r_dat1 <= mac_r;
				alu_r_dat2 <= '0;
			end else if (eval_done) begin
				// value lands in lane 8
				alu_r_dat1.flat <= {{(`GF_VEC_W-`GF_M){1'b0}}, eval_value};
				alu_r_dat2      <= '0;
			end
		end
	end

endmodule

// ==== gf_alu_top.sv ====
// top level of the GF(2^16) vector unit, wiring front end, MAC array, sequencer, result stage
`timescale 1ns/10ps

module gf_alu_top (
	input  logic                 clk,
	input  logic                 rst_b,
	input  logic                 alu_o_sel,
	input  logic                 alu_t_sel,
	input  gf_alu_pkg::alu_op_e  alu_typ_sel,
	input  gf_alu_pkg::gf_vec_u  alu_o_dat,
	input  gf_alu_pkg::gf_vec_u  alu_t_dat,
	output gf_alu_pkg::gf_vec_u  alu_r_dat1,
	output gf_alu_pkg::gf_vec_u  alu_r_dat2,
	output logic                 compute_done
);

	gf_alu_pkg::gf_vec_u  opnd_o;
	gf_alu_pkg::gf_vec_u  opnd_t;
	gf_alu_pkg::alu_op_e  op_typ;
	logic                 op_start;
	logic                 eval_start;
	gf_alu_pkg::gf_vec_u  mac_a;
	gf_alu_pkg::gf_vec_u  mac_b;
	gf_alu_pkg::gf_vec_u  mac_c;
	gf_alu_pkg::gf_vec_u  mac_r;
	logic                 eval_active;
	gf_alu_pkg::gf_elem_t eval_a;
	gf_alu_pkg::gf_elem_t eval_b;
	gf_alu_pkg::gf_elem_t eval_c;
	logic                 eval_done;
	gf_alu_pkg::gf_elem_t eval_value;

	alu_cmd_front u_front (
		.clk(clk), .rst_b(rst_b),
		.alu_o_sel(alu_o_sel), .alu_t_sel(alu_t_sel), .alu_typ_sel(alu_typ_sel),
		.alu_o_dat(alu_o_dat), .alu_t_dat(alu_t_dat), .compute_done(compute_done),
		.opnd_o(opnd_o), .opnd_t(opnd_t), .op_typ(op_typ),
		.op_start(op_start), .eval_start(eval_start)
	);

	gf_mac_array u_mac (
		.clk(clk), .rst_b(rst_b),
		.mac_a(mac_a), .mac_b(mac_b), .mac_c(mac_c), .mac_r(mac_r)
	);

	poly_eval_seq u_eval (
		.clk(clk), .rst_b(rst_b), .eval_start(eval_start),
		.opnd_o(opnd_o), .opnd_t(opnd_t), .mac_lane0(mac_r.lanes[0]),
		.eval_active(eval_active), .eval_a(eval_a), .eval_b(eval_b), .eval_c(eval_c),
		.eval_done(eval_done), .eval_value(eval_value)
	);

	alu_result_stage u_result (
		.clk(clk), .rst_b(rst_b), .op_start(op_start), .op_typ(op_typ),
		.opnd_o(opnd_o), .opnd_t(opnd_t), .mac_r(mac_r),
		.eval_active(eval_active), .eval_a(eval_a), .eval_b(eval_b), .eval_c(eval_c),
		.eval_done(eval_done), .eval_value(eval_value),
		.mac_a(mac_a), .mac_b(mac_b), .mac_c(mac_c),
		.alu_r_dat1(alu_r_dat1), .alu_r_dat2(alu_r_dat2), .compute_done(compute_done)
	);

endmodule

// ==== gf_alu_properties.sv ====
// concurrent checks on the done pulse, MUL latency and EVAL busy, bound into gf_alu_top
`timescale 1ns/10ps

module gf_alu_properties (
	input logic                clk,
	input logic                rst_b,
	input logic                compute_done,
	input logic                op_start,
	input gf_alu_pkg::alu_op_e op_typ,
	input logic                eval_active,
	input logic                busy
);

	// done is a single-cycle pulse
	a_done_single: assert property (@(posedge clk) disable iff (!rst_b)
		compute_done |=> !compute_done)
		else $error("compute_done high on two consecutive cycles");

	// op_start follows acceptance by one cycle, done lands three cycles after that
	a_mul_latency: assert property (@(posedge clk) disable iff (!rst_b)
		(op_start && op_typ == gf_alu_pkg::op_mul) |-> ##1 (!compute_done) [*3] ##1 compute_done)
		else $error("MUL done not exactly four cycles after acceptance");

	a_eval_busy: assert property (@(posedge clk) disable iff (!rst_b)
		eval_active |-> busy)
		else $error("eval_active while the front end is idle");

endmodule

bind gf_alu_top gf_alu_properties u_props (
	.clk(clk), .rst_b(rst_b), .compute_done(compute_done),
	.op_start(op_start), .op_typ(op_typ),
	.eval_active(eval_active), .busy(u_front.busy)
);

// ==== gf_alu_tb.sv ====
// testbench for gf_alu_top with clock, reset, random commands, GF(2^16) model and checks
`timescale 1ns/10ps
`include "gf_alu_consts.svh"

module gf_alu_tb;

	localparam int N_TESTS     = 5;
	localparam int N_CMDS      = 40;
	localparam int CMD_LIMIT   = 40;
	localparam int CYCLE_LIMIT = N_TESTS * N_CMDS * CMD_LIMIT;
	localparam int LAST        = `GF_LANES - 1;

	logic                clk;
	logic                rst_b;
	logic                alu_o_sel;
	logic                alu_t_sel;
	gf_alu_pkg::alu_op_e alu_typ_sel;
	gf_alu_pkg::gf_vec_u alu_o_dat;
	gf_alu_pkg::gf_vec_u alu_t_dat;
	gf_alu_pkg::gf_vec_u alu_r_dat1;
	gf_alu_pkg::gf_vec_u alu_r_dat2;
	logic                compute_done;

	int cycles;
	int checks;
	int errors;
	int tests_done;

	gf_alu_top UUT (
		.clk(clk), .rst_b(rst_b),
		.alu_o_sel(alu_o_sel), .alu_t_sel(alu_t_sel), .alu_typ_sel(alu_typ_sel),
		.alu_o_dat(alu_o_dat), .alu_t_dat(alu_t_dat),
		.alu_r_dat1(alu_r_dat1), .alu_r_dat2(alu_r_dat2), .compute_done(compute_done)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= CYCLE_LIMIT) begin
			$display("run stopped at %0d cycles, the DUT stopped answering", cycles);
			$display("Simulation finished: FAIL");
			$finish;
		end
	end

	// ========================================================================
	// reference model
	// ========================================================================

	// shift-and-add multiply, reduced one bit at a time
	function automatic gf_alu_pkg::gf_elem_t gf_mul(input gf_alu_pkg::gf_elem_t a,
			input gf_alu_pkg::gf_elem_t b);
		gf_alu_pkg::gf_elem_t r;
		r = '0;
		for (int i = `GF_M - 1; i >= 0; i--) begin
			r = r[`GF_M-1] ? ((r << 1) ^ `GF_POLY) : (r << 1);
			if (b[i])
				r = r ^ a;
		end
		return r;
	endfunction

	function automatic gf_alu_pkg::gf_vec_u rand_vec();
		gf_alu_pkg::gf_vec_u v;
		for (int i = 0; i < `GF_LANES; i++)
			v.lanes[i] = gf_alu_pkg::gf_elem_t'($urandom);
		return v;
	endfunction

	function automatic gf_alu_pkg::alu_op_e rand_op();
		case ($urandom_range(3))
			0: return gf_alu_pkg::op_add;
			1: return gf_alu_pkg::op_mul;
			2: return gf_alu_pkg::op_rshift;
			default: return gf_alu_pkg::op_eval;
		endcase
	endfunction

	// ========================================================================
	// compare tasks
	// ========================================================================
	task automatic check_vec(input string name, input gf_alu_pkg::gf_vec_u got,
			input gf_alu_pkg::gf_vec_u exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("** Error at %0t: %s = %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_elem(input string name, input gf_alu_pkg::gf_elem_t got,
			input gf_alu_pkg::gf_elem_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("** Error at %0t: %s = %h, expected %h", $time, name, got, exp);
		end
	endtask

	// one command, then wait for done; with poke set the strobes keep firing while busy
	task automatic issue(input gf_alu_pkg::alu_op_e op, input gf_alu_pkg::gf_vec_u o,
			input gf_alu_pkg::gf_vec_u t, input bit poke, output int lat);
		@(negedge clk);
		alu_typ_sel = op;
		alu_o_dat   = o;
		alu_t_dat   = t;
		alu_o_sel   = 1'b1;
		alu_t_sel   = 1'b1;
		@(negedge clk);
		alu_o_sel = 1'b0;
		alu_t_sel = 1'b0;
		lat = 0;
		do begin
			@(negedge clk);
			lat++;
			if (poke && !compute_done) begin
				alu_typ_sel = rand_op();
				alu_o_dat   = rand_vec();
				alu_t_dat   = rand_vec();
				alu_o_sel   = 1'b1;
				alu_t_sel   = 1'b1;
			end
		end while (!compute_done && lat < 2 * CMD_LIMIT);
		alu_o_sel = 1'b0;
		alu_t_sel = 1'b0;
		if (!compute_done) begin
			errors++;
			$display("no compute_done within %0d cycles of a %s command", lat, op.name());
		end
	endtask

	// want_lat of zero leaves the latency unchecked
	task automatic run_test(input gf_alu_pkg::alu_op_e op, input int want_lat);
		gf_alu_pkg::gf_vec_u  o;
		gf_alu_pkg::gf_vec_u  t;
		gf_alu_pkg::gf_vec_u  e1;
		gf_alu_pkg::gf_vec_u  e2;
		gf_alu_pkg::gf_elem_t acc;
		int                   lat;
		int                   err0;
		err0 = errors;
		for (int n = 0; n < N_CMDS; n++) begin
			o   = rand_vec();
			t   = rand_vec();
			e1  = '0;
			e2  = '0;
			acc = '0;
			case (op)
				gf_alu_pkg::op_add:
					e1.flat = o.flat ^ t.flat;
				gf_alu_pkg::op_mul:
					for (int i = 0; i < `GF_LANES; i++)
						e1.lanes[i] = gf_mul(o.lanes[i], t.lanes[LAST]);
				gf_alu_pkg::op_gt: begin
					// every fourth compare has equal low lanes
					if (n % 4 == 0)
						t.lanes[LAST] = o.lanes[LAST];
					e1.flat[`GF_VEC_W-1] = t.lanes[LAST] > o.lanes[LAST];
				end
				gf_alu_pkg::op_rshift: begin
					for (int i = 1; i < `GF_LANES; i++)
						e1.lanes[i] = o.lanes[i-1];
					e2.lanes[0] = o.lanes[LAST];
				end
				default: begin
					// Horner from the x^8 coefficient down to the constant
					acc = o.lanes[0];
					for (int i = 1; i < `GF_LANES; i++)
						acc = gf_mul(acc, t.lanes[LAST]) ^ o.lanes[i];
					e1.lanes[LAST] = acc;
				end
			endcase
			issue(op, o, t, op == gf_alu_pkg::op_eval, lat);
			if (want_lat > 0 && lat != want_lat) begin
				errors++;
				$display("%s done came %0d cycles after acceptance, not %0d",
					op.name(), lat, want_lat);
			end
			check_vec("alu_r_dat1", alu_r_dat1, e1);
			check_vec("alu_r_dat2", alu_r_dat2, e2);
			if (op == gf_alu_pkg::op_eval) begin
				check_elem("alu_r_dat1.lanes[8]", alu_r_dat1.lanes[LAST], acc);
				// strobes sent while busy must not start a second command
				repeat (4) begin
					@(negedge clk);
					if (compute_done) begin
						errors++;
						$display("a second compute_done followed one EVAL command");
					end
				end
			end
		end
		tests_done++;
		$display("test %s: %0d commands, %0d errors", op.name(), N_CMDS, errors - err0);
	endtask

	initial begin
		int seed_val;
		seed_val    = $urandom(32'he583_f071);
		cycles      = 0;
		checks      = 0;
		errors      = 0;
		tests_done  = 0;
		rst_b       = 1'b0;
		alu_o_sel   = 1'b0;
		alu_t_sel   = 1'b0;
		alu_typ_sel = gf_alu_pkg::op_add;
		alu_o_dat   = '0;
		alu_t_dat   = '0;
		repeat (16) @(posedge clk);
		@(negedge clk);
		rst_b = 1'b1;
		run_test(gf_alu_pkg::op_add, 1);
		run_test(gf_alu_pkg::op_mul, 4);
		run_test(gf_alu_pkg::op_gt, 1);
		run_test(gf_alu_pkg::op_rshift, 1);
		run_test(gf_alu_pkg::op_eval, 0);
		$display("tests %0d, checks %0d, errors %0d", tests_done, checks, errors);
		if (errors == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

// ==== sim.f ====
+incdir+.
gf_alu_pkg.sv
alu_cmd_front.sv
gf_mac_array.sv
poly_eval_seq.sv
alu_result_stage.sv
gf_alu_top.sv
gf_alu_properties.sv
gf_alu_tb.sv
